// File: common/bpPkg.sv
`default_nettype none

package bpPkg;

    // Halfword PC and fetch block geometry
    localparam int pcWidth = 31;
    localparam int fetchOffBits = 2;
    localparam int fetchIdBits = 3;
    localparam int btbIdxBits = 4;
    localparam int ctrIdxBits = 6;
    localparam int rstackIdxBits = 3;

    typedef logic [fetchIdBits-1:0] FetchId_t;
    typedef logic [fetchOffBits-1:0] FetchOff_t;
    typedef logic [rstackIdxBits-1:0] RStackIdx_t;

    typedef enum logic [1:0] {btJump, btBranch, btCall, btReturn} BranchType_t;
    typedef enum logic [1:0] {raNone, raPush, raPop} RetAction_t;

    typedef struct packed {
        logic valid;
        BranchType_t brType;
        FetchOff_t offs;
        logic taken;
        logic [pcWidth-1:0] dst;
    } PredBranch;

    typedef struct packed {
        logic valid;
        logic [pcWidth-1:0] pc;
        BranchType_t brType;
        logic [pcWidth-1:0] dst;
    } BtbUpdate;

    typedef struct packed {
        logic valid;
        FetchId_t fetchId;
        logic [pcWidth-1:0] dst;
        // Stack action of the mispredicting instruction itself
        RetAction_t retAct;
    } Mispredict;

    typedef struct packed {
        logic valid;
        FetchId_t fetchId;
        logic taken;
    } BranchOutcome;

    typedef struct packed {
        logic valid;
        FetchId_t fetchId;
    } FetchLimit;

    typedef struct packed {
        logic [pcWidth-1:0] pc;
        FetchOff_t offs;
        logic hadBranch;
        RStackIdx_t rIdx;
    } BackupEntry;

endpackage

`default_nettype wire

// File: bp/branchTargetBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module branchTargetBuffer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [bpPkg::pcWidth-1:0]    lookupPc,
    output bpPkg::PredBranch            hit,
    input  bpPkg::BtbUpdate             btUpdate
);
    localparam int pcW = bpPkg::pcWidth;
    localparam int offW = bpPkg::fetchOffBits;
    localparam int idxW = bpPkg::btbIdxBits;
    localparam int tagW = pcW - offW - idxW;
    localparam int entries = 1 << idxW;

    typedef struct packed {
        logic [tagW-1:0] tag;
        bpPkg::FetchOff_t offs;
        bpPkg::BranchType_t brType;
        logic [pcW-1:0] dst;
    } BtbEntry;

    BtbEntry table_ [entries];
    logic [entries-1:0] entryValid;

    logic [idxW-1:0] rdIdx;
    logic [idxW-1:0] wrIdx;
    BtbEntry rdEntry;

    assign rdIdx = lookupPc[offW +: idxW];
    assign wrIdx = btUpdate.pc[offW +: idxW];
    assign rdEntry = table_[rdIdx];

    // A branch before the fetch entry offset is not part of this fetch
    always_comb begin
        hit.valid = entryValid[rdIdx] && rdEntry.tag == lookupPc[pcW-1:offW+idxW]
            && rdEntry.offs >= lookupPc[offW-1:0];
        hit.brType = rdEntry.brType;
        hit.offs = rdEntry.offs;
        hit.taken = 1'b1;
        hit.dst = rdEntry.dst;
    end

    always_ff @(posedge clk) begin
        if (rst)
            entryValid <= '0;
        else if (btUpdate.valid)
            entryValid[wrIdx] <= 1'b1;
        if (btUpdate.valid)
            table_[wrIdx] <= '{tag: btUpdate.pc[pcW-1:offW+idxW], offs: btUpdate.pc[offW-1:0],
                brType: btUpdate.brType, dst: btUpdate.dst};
    end

endmodule

`default_nettype wire

// File: bp/directionCounters.sv
`timescale 1ns/10ps
`default_nettype none

module directionCounters (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [bpPkg::pcWidth-1:0]    lookupPc,
    output logic                        taken,
    input  wire                         trainValid,
    input  wire                         trainTaken,
    input  wire [bpPkg::pcWidth-1:0]    trainPc
);
    localparam int idxW = bpPkg::ctrIdxBits;
    localparam int entries = 1 << idxW;

    logic [1:0] ctr [entries];
    logic [idxW-1:0] trainIdx;
    logic [1:0] trainCur;

    // Low PC bits hold block index and branch offset
    assign taken = ctr[lookupPc[idxW-1:0]][1];
    assign trainIdx = trainPc[idxW-1:0];
    assign trainCur = ctr[trainIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Weakly not-taken
            for (int i = 0; i < entries; i++)
                ctr[i] <= 2'b01;
        end else if (trainValid) begin
            if (trainTaken && trainCur != 2'b11)
                ctr[trainIdx] <= trainCur + 2'b01;
            else if (!trainTaken && trainCur != 2'b00)
                ctr[trainIdx] <= trainCur - 2'b01;
        end
    end

endmodule

`default_nettype wire

// File: bp/returnStack.sv
`timescale 1ns/10ps
`default_nettype none

module returnStack (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pcValid,
    input  bpPkg::PredBranch            predBr,
    input  wire [bpPkg::pcWidth-1:0]    blockPc,
    output logic [bpPkg::pcWidth-1:0]   top,
    output bpPkg::RStackIdx_t           idx,
    input  wire                         restoreValid,
    input  bpPkg::RStackIdx_t           restoreIdx
);
    localparam int pcW = bpPkg::pcWidth;
    localparam int offW = bpPkg::fetchOffBits;
    localparam int depth = 1 << bpPkg::rstackIdxBits;

    logic [pcW-1:0] stack [depth];
    bpPkg::RStackIdx_t ptr;
    logic [pcW-1:0] pushAddr;
    logic doPush;
    logic doPop;

    assign top = stack[ptr];
    assign idx = ptr;

    // Return lands on the halfword after the call
    assign pushAddr = {blockPc[pcW-1:offW], predBr.offs} + 1'b1;
    assign doPush = pcValid && predBr.valid && predBr.taken && predBr.brType == bpPkg::btCall;
    assign doPop = pcValid && predBr.valid && predBr.brType == bpPkg::btReturn;

    always_ff @(posedge clk) begin
        if (rst)
            ptr <= '0;
        else if (restoreValid)
            ptr <= restoreIdx;
        else if (doPush)
            ptr <= ptr + 1'b1;
        else if (doPop)
            ptr <= ptr - 1'b1;

        // Entries are kept as they are on a restore
        if (!restoreValid && doPush)
            stack[ptr + 1'b1] <= pushAddr;
    end

endmodule

`default_nettype wire

// File: bp/predictionBackup.sv
`timescale 1ns/10ps
`default_nettype none

module predictionBackup (
    input  wire                 clk,
    input  wire                 we,
    input  bpPkg::FetchId_t     waddr,
    input  bpPkg::BackupEntry   wdata,
    input  wire                 re,
    input  bpPkg::FetchId_t     raddr,
    output bpPkg::BackupEntry   rdata
);
    localparam int entries = 1 << bpPkg::fetchIdBits;

    bpPkg::BackupEntry mem [entries];

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        if (re)
            rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: bp/updateQueue.sv
`timescale 1ns/10ps
`default_nettype none

module updateQueue (
    input  wire                     clk,
    input  wire                     rst,
    input  bpPkg::BranchOutcome     in,
    input  wire                     deq,
    output bpPkg::BranchOutcome     head,
    output logic [2:0]              count
);
    bpPkg::BranchOutcome mem [4];
    logic [1:0] rdPtr;
    logic [1:0] wrPtr;
    logic doEnq;
    logic doDeq;

    assign doEnq = in.valid && count != 3'd4;
    assign doDeq = deq && count != 3'd0;

    always_comb begin
        head = mem[rdPtr];
        head.valid = count != 3'd0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doEnq)
                wrPtr <= wrPtr + 1'b1;
            if (doDeq)
                rdPtr <= rdPtr + 1'b1;
            count <= count + {2'b00, doEnq} - {2'b00, doDeq};
        end
        if (doEnq)
            mem[wrPtr] <= in;
    end

endmodule

`default_nettype wire

// File: bp/branchPredictor.sv
`timescale 1ns/10ps
`default_nettype none

module branchPredictor #(
    parameter logic [bpPkg::pcWidth-1:0] entryPoint = '0
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pcValid,
    input  bpPkg::FetchId_t             fetchId,
    input  bpPkg::Mispredict            mispr,
    input  bpPkg::BranchOutcome         outcome,
    output logic [bpPkg::pcWidth-1:0]   pc,
    output bpPkg::PredBranch            predBr,
    output bpPkg::FetchLimit            fetchLimit,
    output logic [bpPkg::pcWidth-1:0]   lookupPc,
    input  bpPkg::PredBranch            btbHit,
    input  wire                         ctrTaken,
    input  wire [bpPkg::pcWidth-1:0]    retTop,
    input  bpPkg::RStackIdx_t           rIdx,
    output logic                        restoreValid,
    output bpPkg::RStackIdx_t           restoreIdx,
    output logic                        bkWe,
    output bpPkg::FetchId_t             bkWaddr,
    output bpPkg::BackupEntry           bkWdata,
    output logic                        bkRe,
    output bpPkg::FetchId_t             bkRaddr,
    input  bpPkg::BackupEntry           bkRdata,
    output bpPkg::BranchOutcome         qIn,
    output logic                        qDeq,
    input  bpPkg::BranchOutcome         qHead,
    input  wire [2:0]                   qCount,
    output bpPkg::BranchOutcome         train,
    output logic [bpPkg::pcWidth-1:0]   trainPc
);
    localparam int pcW = bpPkg::pcWidth;
    localparam int offW = bpPkg::fetchOffBits;

    logic [pcW-1:0] pcReg;
    logic [pcW-1:0] nextPc;
    logic ignorePred;
    logic recValid;
    bpPkg::RetAction_t recRetAct;
    bpPkg::BranchOutcome updActive;

    assign pc = pcReg;

    // Counter lookup uses the offset of the branch found in the target buffer
    assign lookupPc = {pcReg[pcW-1:offW], btbHit.offs};

    always_comb begin
        predBr = '0;
        nextPc = {pcReg[pcW-1:offW] + 1'b1, {offW{1'b0}}};
        if (!ignorePred && btbHit.valid) begin
            predBr = btbHit;
            case (btbHit.brType)
                bpPkg::btReturn: begin
                    predBr.taken = 1'b1;
                    predBr.dst = retTop;
                end
                bpPkg::btBranch: predBr.taken = ctrTaken;
                default: predBr.taken = 1'b1;
            endcase
            if (predBr.taken)
                nextPc = predBr.dst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= entryPoint;
            ignorePred <= 1'b1;
        end else if (mispr.valid) begin
            // Redirect, next cycle fetches the corrected target unpredicted
            pcReg <= mispr.dst;
            ignorePred <= 1'b1;
        end else if (pcValid) begin
            pcReg <= nextPc;
            ignorePred <= 1'b0;
        end
    end

    // Save fetch-time state under the fetch ID
    assign bkWe = pcValid;
    assign bkWaddr = fetchId;
    assign bkWdata = '{pc: pcReg, offs: predBr.offs, hadBranch: predBr.valid, rIdx: rIdx};

    // One backup read per cycle, mispredicts first
    assign bkRe = mispr.valid || qHead.valid;
    assign bkRaddr = mispr.valid ? mispr.fetchId : qHead.fetchId;
    assign qDeq = !mispr.valid && qHead.valid;
    assign qIn = outcome;

    always_ff @(posedge clk) begin
        if (rst) begin
            recValid <= 1'b0;
            updActive.valid <= 1'b0;
        end else begin
            recValid <= mispr.valid;
            updActive.valid <= qDeq;
        end
        recRetAct <= mispr.retAct;
        updActive.fetchId <= qHead.fetchId;
        updActive.taken <= qHead.taken;
    end

    // Pointer at fetch time, then the mispredicting instruction's own action
    always_comb begin
        restoreValid = recValid;
        restoreIdx = bkRdata.rIdx;
        case (recRetAct)
            bpPkg::raPush: restoreIdx = bkRdata.rIdx + 1'b1;
            bpPkg::raPop: restoreIdx = bkRdata.rIdx - 1'b1;
            default: ;
        endcase
    end

    // Train only where a prediction was actually made
    always_comb begin
        train = updActive;
        train.valid = updActive.valid && bkRdata.hadBranch;
        trainPc = {bkRdata.pc[pcW-1:offW], bkRdata.offs};
    end

    // Keep fetch off IDs still needed by pending updates
    always_comb begin
        fetchLimit.valid = (qCount != 3'd0) || outcome.valid;
        fetchLimit.fetchId = qHead.valid ? qHead.fetchId : outcome.fetchId;
    end

endmodule

`default_nettype wire

// File: design/fetchPredictTop.sv
`timescale 1ns/10ps
`default_nettype none

module fetchPredictTop #(
    parameter logic [bpPkg::pcWidth-1:0] entryPoint = 31'h0000_8000
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pcValid,
    input  bpPkg::FetchId_t             fetchId,
    input  bpPkg::Mispredict            mispr,
    input  bpPkg::BtbUpdate             btUpdate,
    input  bpPkg::BranchOutcome         outcome,
    output logic [bpPkg::pcWidth-1:0]   pc,
    output bpPkg::PredBranch            predBr,
    output bpPkg::FetchLimit            fetchLimit,
    output logic [bpPkg::pcWidth-1:0]   retAddr
);
    logic [bpPkg::pcWidth-1:0] lookupPc;
    logic [bpPkg::pcWidth-1:0] trainPc;
    bpPkg::PredBranch btbHit;
    logic ctrTaken;
    bpPkg::RStackIdx_t rIdx;
    bpPkg::RStackIdx_t restoreIdx;
    logic restoreValid;
    logic bkWe;
    logic bkRe;
    bpPkg::FetchId_t bkWaddr;
    bpPkg::FetchId_t bkRaddr;
    bpPkg::BackupEntry bkWdata;
    bpPkg::BackupEntry bkRdata;
    bpPkg::BranchOutcome qIn;
    bpPkg::BranchOutcome qHead;
    bpPkg::BranchOutcome train;
    logic qDeq;
    logic [2:0] qCount;

    branchPredictor #(.entryPoint(entryPoint)) predictor (
        .clk(clk), .rst(rst), .pcValid(pcValid), .fetchId(fetchId), .mispr(mispr),
        .outcome(outcome), .pc(pc), .predBr(predBr), .fetchLimit(fetchLimit),
        .lookupPc(lookupPc), .btbHit(btbHit), .ctrTaken(ctrTaken), .retTop(retAddr),
        .rIdx(rIdx), .restoreValid(restoreValid), .restoreIdx(restoreIdx),
        .bkWe(bkWe), .bkWaddr(bkWaddr), .bkWdata(bkWdata), .bkRe(bkRe),
        .bkRaddr(bkRaddr), .bkRdata(bkRdata), .qIn(qIn), .qDeq(qDeq), .qHead(qHead),
        .qCount(qCount), .train(train), .trainPc(trainPc)
    );

    // Target buffer matches on the fetch PC itself
    branchTargetBuffer btb (
        .clk(clk), .rst(rst), .lookupPc(pc), .hit(btbHit), .btUpdate(btUpdate)
    );

    directionCounters counters (
        .clk(clk), .rst(rst), .lookupPc(lookupPc), .taken(ctrTaken),
        .trainValid(train.valid), .trainTaken(train.taken), .trainPc(trainPc)
    );

    returnStack rstack (
        .clk(clk), .rst(rst), .pcValid(pcValid), .predBr(predBr), .blockPc(pc),
        .top(retAddr), .idx(rIdx), .restoreValid(restoreValid), .restoreIdx(restoreIdx)
    );

    predictionBackup backup (
        .clk(clk), .we(bkWe), .waddr(bkWaddr), .wdata(bkWdata),
        .re(bkRe), .raddr(bkRaddr), .rdata(bkRdata)
    );

    updateQueue updQueue (
        .clk(clk), .rst(rst), .in(qIn), .deq(qDeq), .head(qHead), .count(qCount)
    );

endmodule

`default_nettype wire

// File: tb/fetchPredictTb.sv
`timescale 1ns/10ps
`default_nettype none

module fetchPredictTb;
    localparam int pcW = bpPkg::pcWidth;
    localparam logic [pcW-1:0] entryPc = 31'h0000_8000;
    // Tests run for about 50 cycles
    localparam int maxCycles = 400;

    logic clk;
    logic rst;
    logic pcValid;
    bpPkg::FetchId_t fetchId;
    bpPkg::Mispredict mispr;
    bpPkg::BtbUpdate btUpdate;
    bpPkg::BranchOutcome outcome;
    logic [pcW-1:0] pc;
    bpPkg::PredBranch predBr;
    bpPkg::FetchLimit fetchLimit;
    logic [pcW-1:0] retAddr;

    // Reference model of the fetch PC rules
    logic [pcW-1:0] mPc;
    logic mIgnore;
    logic mBV [16];
    logic [pcW-1:0] mBPc [16];
    bpPkg::BranchType_t mBType [16];
    logic [pcW-1:0] mBDst [16];
    logic [1:0] mCtr [64];
    logic [pcW-1:0] mStack [8];
    logic [2:0] mSp;
    logic [pcW-1:0] bkPc [8];
    logic [1:0] bkOffs [8];
    logic bkHad [8];
    logic [2:0] bkSp [8];

    bpPkg::FetchId_t nextId;
    bpPkg::FetchId_t lastId;
    logic [31:0] lcgState;
    int errors;
    int checks;
    int testsRun;
    int cycleCount;

    fetchPredictTop #(.entryPoint(entryPc)) uut (
        .clk(clk), .rst(rst), .pcValid(pcValid), .fetchId(fetchId), .mispr(mispr),
        .btUpdate(btUpdate), .outcome(outcome), .pc(pc), .predBr(predBr),
        .fetchLimit(fetchLimit), .retAddr(retAddr)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Random tag above a fixed table index
    function automatic logic [pcW-1:0] pickPc(input logic [3:0] idx, input logic aligned);
        logic [31:0] r;
        r = lcgNext();
        return {r[31:7], idx, aligned ? 2'b00 : r[1:0]};
    endfunction

    function automatic bpPkg::PredBranch predictModel();
        bpPkg::PredBranch p;
        logic [3:0] i;
        p = '0;
        i = mPc[5:2];
        if (!mIgnore && mBV[i] && mBPc[i][pcW-1:2] == mPc[pcW-1:2]
                && mBPc[i][1:0] >= mPc[1:0]) begin
            p.valid = 1'b1;
            p.brType = mBType[i];
            p.offs = mBPc[i][1:0];
            p.taken = 1'b1;
            p.dst = mBDst[i];
            if (p.brType == bpPkg::btReturn)
                p.dst = mStack[mSp];
            else if (p.brType == bpPkg::btBranch)
                p.taken = mCtr[{i, p.offs}][1];
        end
        return p;
    endfunction

    task nextCycle();
        @(posedge clk);
        #1;
    endtask

    task check(input string name, input logic [63:0] expected, input logic [63:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task reportTest(input string name, input int errStart);
        testsRun = testsRun + 1;
        if (errors == errStart)
            $display("Test %s: passed", name);
        else
            $display("Test %s: failed with %0d errors", name, errors - errStart);
    endtask

    // One fetch cycle checked against the model
    task fetchStep(input string name);
        bpPkg::PredBranch exp;
        logic [pcW-1:0] nxt;
        bpPkg::FetchId_t id;
        id = nextId;
        nextId = nextId + 1'b1;
        lastId = id;
        exp = predictModel();
        nxt = (exp.valid && exp.taken) ? exp.dst : {mPc[pcW-1:2] + 29'd1, 2'b00};
        pcValid = 1'b1;
        fetchId = id;
        #1;
        check(name, mPc, pc);
        check(name, exp, predBr);
        bkPc[id] = mPc;
        bkOffs[id] = exp.offs;
        bkHad[id] = exp.valid;
        bkSp[id] = mSp;
        if (exp.valid && exp.brType == bpPkg::btCall) begin
            mSp = mSp + 1'b1;
            mStack[mSp] = {mPc[pcW-1:2], exp.offs} + 31'd1;
        end else if (exp.valid && exp.brType == bpPkg::btReturn) begin
            mSp = mSp - 1'b1;
        end
        mPc = nxt;
        mIgnore = 1'b0;
        nextCycle();
        pcValid = 1'b0;
    endtask

    task install(input logic [pcW-1:0] at, input bpPkg::BranchType_t t,
                 input logic [pcW-1:0] dst);
        btUpdate = '{1'b1, at, t, dst};
        nextCycle();
        btUpdate = '0;
        mBV[at[5:2]] = 1'b1;
        mBPc[at[5:2]] = at;
        mBType[at[5:2]] = t;
        mBDst[at[5:2]] = dst;
    endtask

    task redirect(input bpPkg::FetchId_t id, input logic [pcW-1:0] dst, input string name);
        mispr = '{1'b1, id, dst, bpPkg::raNone};
        nextCycle();
        mispr = '0;
        check(name, dst, pc);
        check(name, 1'b0, predBr.valid);
        mPc = dst;
        mIgnore = 1'b1;
        mSp = bkSp[id];
        // Pointer restore lands one cycle after the redirect
        nextCycle();
    endtask

    // Redirect to the previous block so the target block is fetched with prediction
    task gotoBlock(input logic [pcW-1:0] at, input string name);
        redirect(lastId, {at[pcW-1:2] - 29'd1, 2'b00}, name);
        fetchStep(name);
    endtask

    task trainModel(input bpPkg::FetchId_t id, input logic taken);
        logic [5:0] j;
        j = {bkPc[id][5:2], bkOffs[id]};
        if (bkHad[id]) begin
            if (taken && mCtr[j] != 2'b11)
                mCtr[j] = mCtr[j] + 2'b01;
            else if (!taken && mCtr[j] != 2'b00)
                mCtr[j] = mCtr[j] - 2'b01;
        end
    endtask

    task applyOutcome(input bpPkg::FetchId_t id, input logic taken);
        outcome = '{1'b1, id, taken};
        nextCycle();
        outcome = '0;
        trainModel(id, taken);
    endtask

    // Wait for an empty queue plus one cycle for the backup read and one for training
    task waitDrain();
        #1;
        while (fetchLimit.valid)
            nextCycle();
        repeat (2) nextCycle();
    endtask

    task resetAndSequential();
        int errStart;
        errStart = errors;
        check("resetPc", entryPc, pc);
        check("resetPred", 1'b0, predBr.valid);
        check("resetLimit", 1'b0, fetchLimit.valid);
        repeat (4) fetchStep("sequential");
        check("sequentialPc", entryPc + 31'd16, pc);
        reportTest("reset and sequential fetch", errStart);
    endtask

    task takenJump();
        logic [pcW-1:0] at;
        logic [pcW-1:0] dst;
        int errStart;
        errStart = errors;
        at = pickPc(4'd3, 1'b0);
        dst = pickPc(4'd9, 1'b1);
        install(at, bpPkg::btJump, dst);
        gotoBlock(at, "jumpRedirect");
        fetchStep("jumpFetch");
        check("jumpTarget", dst, pc);
        reportTest("taken jump", errStart);
    endtask

    task callAndReturn();
        logic [pcW-1:0] callPc;
        logic [pcW-1:0] callDst;
        logic [pcW-1:0] tmp;
        int errStart;
        errStart = errors;
        callPc = pickPc(4'd5, 1'b0);
        callDst = pickPc(4'd11, 1'b1);
        tmp = pickPc(4'd11, 1'b0);
        install(callPc, bpPkg::btCall, callDst);
        install({callDst[pcW-1:2], tmp[1:0]}, bpPkg::btReturn, '0);
        gotoBlock(callPc, "callRedirect");
        fetchStep("callFetch");
        check("callPush", callPc + 31'd1, retAddr);
        fetchStep("returnFetch");
        check("returnTarget", callPc + 31'd1, pc);
        reportTest("call and return", errStart);
    endtask

    task mispredictRestore();
        logic [pcW-1:0] call1;
        logic [pcW-1:0] t1;
        logic [pcW-1:0] call2;
        logic [pcW-1:0] dstM;
        logic [pcW-1:0] prior;
        bpPkg::FetchId_t id2;
        int errStart;
        errStart = errors;
        call1 = pickPc(4'd7, 1'b0);
        t1 = pickPc(4'd12, 1'b1);
        call2 = pickPc(4'd13, 1'b0);
        // Second call sits in the block after the first call's target
        call2 = {t1[pcW-1:6], call2[5:0]};
        dstM = pickPc(4'd14, 1'b1);
        install(call1, bpPkg::btCall, t1);
        install(call2, bpPkg::btCall, pickPc(4'd15, 1'b1));
        gotoBlock(call1, "misprCallRedirect");
        fetchStep("call1Fetch");
        prior = call1 + 31'd1;
        check("call1Push", prior, retAddr);
        fetchStep("t1Fetch");
        fetchStep("call2Fetch");
        id2 = lastId;
        check("call2Push", call2 + 31'd1, retAddr);
        redirect(id2, dstM, "misprRedirect");
        check("misprRestore", prior, retAddr);
        reportTest("mispredict and stack restore", errStart);
    endtask

    task counterTraining();
        logic [pcW-1:0] brPc;
        logic [pcW-1:0] brDst;
        bpPkg::FetchId_t id;
        int errStart;
        errStart = errors;
        brPc = pickPc(4'd1, 1'b0);
        brDst = pickPc(4'd10, 1'b1);
        install(brPc, bpPkg::btBranch, brDst);
        gotoBlock(brPc, "branchRedirect");
        fetchStep("branchCold");
        id = lastId;
        check("branchSequential", {brPc[pcW-1:2] + 29'd1, 2'b00}, pc);
        applyOutcome(id, 1'b1);
        applyOutcome(id, 1'b1);
        waitDrain();
        gotoBlock(brPc, "branchRedirect");
        fetchStep("branchTrained");
        check("branchTakenTarget", brDst, pc);
        reportTest("counter training", errStart);
    endtask

    task fetchLimitHold();
        bpPkg::FetchId_t idA;
        bpPkg::FetchId_t idB;
        bpPkg::FetchLimit expLim;
        logic [pcW-1:0] dstM;
        int errStart;
        errStart = errors;
        fetchStep("limitFetchA");
        idA = lastId;
        fetchStep("limitFetchB");
        idB = lastId;
        dstM = pickPc(4'd14, 1'b1);
        expLim = '{1'b1, idA};
        outcome = '{1'b1, idA, 1'b0};
        mispr = '{1'b1, idB, dstM, bpPkg::raNone};
        #1;
        check("limitIncoming", expLim, fetchLimit);
        // Mispredict held a second cycle so the queued outcome cannot leave
        nextCycle();
        outcome = '{1'b1, idB, 1'b0};
        #1;
        check("limitBlocked", expLim, fetchLimit);
        nextCycle();
        outcome = '0;
        mispr = '0;
        #1;
        check("limitQueued", expLim, fetchLimit);
        check("limitRedirect", dstM, pc);
        mPc = dstM;
        mIgnore = 1'b1;
        mSp = bkSp[idB];
        trainModel(idA, 1'b0);
        trainModel(idB, 1'b0);
        // Queued outcomes leave one per cycle once the mispredict is gone
        nextCycle();
        expLim = '{1'b1, idB};
        check("limitNext", expLim, fetchLimit);
        nextCycle();
        check("limitDrained", 1'b0, fetchLimit.valid);
        reportTest("fetch limit", errStart);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        pcValid = 1'b0;
        fetchId = '0;
        mispr = '0;
        btUpdate = '0;
        outcome = '0;
        lcgState = 32'h52ab6088;
        errors = 0;
        checks = 0;
        testsRun = 0;
        cycleCount = 0;
        nextId = '0;
        lastId = '0;
        mPc = entryPc;
        mIgnore = 1'b1;
        mSp = '0;
        for (int i = 0; i < 16; i++)
            mBV[i] = 1'b0;
        for (int i = 0; i < 64; i++)
            mCtr[i] = 2'b01;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        resetAndSequential();
        takenJump();
        callAndReturn();
        mispredictRestore();
        counterTraining();
        fetchLimitHold();

        $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/bpPkg.sv
bp/branchTargetBuffer.sv
bp/directionCounters.sv
bp/returnStack.sv
bp/predictionBackup.sv
bp/updateQueue.sv
bp/branchPredictor.sv
design/fetchPredictTop.sv
tb/fetchPredictTb.sv
